// File: dv/rf_model.svh
/*
  Reference model of the register file block
  Two word arrays with write steering and read prediction
*/

`ifndef RF_MODEL_SVH
`define RF_MODEL_SVH

rf_word_t int_mem [RfNumRegs];
rf_word_t fp_mem  [RfNumRegs];

// Both files come out of reset all zero
task automatic clear_model();
  for (int i = 0; i < RfNumRegs; i++) begin
    int_mem[i] = '0;
    fp_mem[i]  = '0;
  end
endtask

// x0 drops its writes, f0 keeps them
task automatic apply_write(input rf_wr_req_t wr);
  if (wr.we) begin
    if (wr.fp_sel) begin
      fp_mem[wr.addr] = wr.data;
    end else if (wr.addr != '0) begin
      int_mem[wr.addr] = wr.data;
    end
  end
endtask

// Called before the same edge's write is applied
function automatic rf_word_t predict_read(input rf_rd_req_t req);
  rf_word_t word;
  if (req.fp_sel) begin
    word = fp_mem[req.addr];
  end else if (req.addr == '0) begin
    word = '0;
  end else begin
    word = int_mem[req.addr];
  end
  return word;
endfunction

`endif

// File: dv/rf_subsys_tb.sv
/*
  Testbench for the register file block
  Directed and random reads and writes checked against a two-array model
*/

`timescale 1ns/1ps
`default_nettype none

module rf_subsys_tb import rf_pkg::*; ();

  localparam int ClkPeriod      = 8;
  localparam int ResetCycles    = 5;
  localparam int DirectedCycles = 48;
  localparam int NumRandom      = 2000;
  localparam int TimeoutNs      =
    (ResetCycles + DirectedCycles + NumRandom + 100) * ClkPeriod;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  rf_rd_req_t rd_req_a;
  rf_rd_req_t rd_req_b;
  rf_wr_req_t wr_req;
  rf_word_t   rdata_a;
  rf_word_t   rdata_b;
  logic       alert_major;

  integer     seed = 32'h7b1c;

  // Expected read data for the edge just taken
  rf_word_t   exp_a;
  rf_word_t   exp_b;
  rf_rd_req_t chk_req_a;
  rf_rd_req_t chk_req_b;

  `include "rf_model.svh"

  rf_subsys_top UUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_req_a_i   (rd_req_a),
    .rd_req_b_i   (rd_req_b),
    .wr_req_i     (wr_req),
    .rdata_a_o    (rdata_a),
    .rdata_b_o    (rdata_b),
    .alert_major_o(alert_major)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic rf_rd_req_t make_read(input logic fp_sel, input rf_addr_t addr);
    rf_rd_req_t req;
    req.fp_sel = fp_sel;
    req.addr   = addr;
    return req;
  endfunction

  function automatic rf_wr_req_t make_write(input logic we, input logic fp_sel,
                                            input rf_addr_t addr, input rf_word_t data);
    rf_wr_req_t wr;
    wr.we     = we;
    wr.fp_sel = fp_sel;
    wr.addr   = addr;
    wr.data   = data;
    return wr;
  endfunction

  task automatic report_mismatch(input string what, input rf_word_t got, input rf_word_t want);
    $display("Mismatch at %0t ns: %s returned %08h, expected %08h", $time, what, got, want);
    $display("Simulation failed");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_outputs();
    a_alert_low: assert (alert_major === 1'b0) else begin
      report_mismatch("alert_major_o", {31'b0, alert_major}, '0);
    end
    a_port_a: assert (rdata_a === exp_a) else begin
      report_mismatch($sformatf("port A read of %s reg %0d",
                                chk_req_a.fp_sel ? "fp" : "int", chk_req_a.addr),
                      rdata_a, exp_a);
    end
    a_port_b: assert (rdata_b === exp_b) else begin
      report_mismatch($sformatf("port B read of %s reg %0d",
                                chk_req_b.fp_sel ? "fp" : "int", chk_req_b.addr),
                      rdata_b, exp_b);
    end
  endtask

  // Check the last edge's reads, then drive the next request set
  task automatic drive_cycle(input rf_rd_req_t req_a, input rf_rd_req_t req_b,
                             input rf_wr_req_t wr);
    @(posedge clk_i);
    #1;
    check_outputs();
    rd_req_a  = req_a;
    rd_req_b  = req_b;
    wr_req    = wr;
    exp_a     = predict_read(req_a);
    exp_b     = predict_read(req_b);
    chk_req_a = req_a;
    chk_req_b = req_b;
    apply_write(wr);
  endtask

  // Low addresses come up often so x0, f0 and collisions get hit
  task automatic pick_addr(output rf_addr_t addr);
    if (($random(seed) & 7) == 0) begin
      addr = rf_addr_t'($random(seed) & 3);
    end else begin
      addr = rf_addr_t'($random(seed));
    end
  endtask

  task automatic random_cycle();
    rf_rd_req_t req_a;
    rf_rd_req_t req_b;
    rf_wr_req_t wr;
    req_a.fp_sel = $random(seed);
    pick_addr(req_a.addr);
    req_b.fp_sel = $random(seed);
    pick_addr(req_b.addr);
    wr.we     = (($random(seed) & 3) != 0);
    wr.fp_sel = $random(seed);
    pick_addr(wr.addr);
    wr.data   = $random(seed);
    drive_cycle(req_a, req_b, wr);
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    rst_ni    = 1'b0;
    rd_req_a  = '0;
    rd_req_b  = '0;
    wr_req    = '0;
    exp_a     = '0;
    exp_b     = '0;
    chk_req_a = '0;
    chk_req_b = '0;
    clear_model();

    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni    = 1'b1;

    // Every register of both files reads zero after reset
    for (int i = 0; i < RfNumRegs; i++) begin
      drive_cycle(make_read(1'b0, rf_addr_t'(i)), make_read(1'b1, rf_addr_t'(31 - i)),
                  make_write(1'b0, 1'b0, '0, '0));
    end

    // Integer write leaves the FP register at the same index alone
    drive_cycle(make_read(1'b0, 5'd5), make_read(1'b1, 5'd5),
                make_write(1'b1, 1'b0, 5'd5, 32'ha5a5_0005));
    drive_cycle(make_read(1'b0, 5'd5), make_read(1'b1, 5'd5),
                make_write(1'b0, 1'b0, '0, '0));

    // x0 stays zero, f0 holds data
    drive_cycle(make_read(1'b0, 5'd0), make_read(1'b1, 5'd0),
                make_write(1'b1, 1'b0, 5'd0, 32'hdead_beef));
    drive_cycle(make_read(1'b0, 5'd0), make_read(1'b1, 5'd0),
                make_write(1'b1, 1'b1, 5'd0, 32'h1234_5678));
    drive_cycle(make_read(1'b0, 5'd0), make_read(1'b1, 5'd0),
                make_write(1'b0, 1'b0, '0, '0));

    // Same-edge read and write give old data first
    drive_cycle(make_read(1'b0, 5'd7), make_read(1'b1, 5'd9),
                make_write(1'b1, 1'b0, 5'd7, 32'h1111_0007));
    drive_cycle(make_read(1'b0, 5'd7), make_read(1'b1, 5'd9),
                make_write(1'b1, 1'b0, 5'd7, 32'h2222_0007));
    drive_cycle(make_read(1'b1, 5'd9), make_read(1'b0, 5'd7),
                make_write(1'b1, 1'b1, 5'd9, 32'h3333_0009));
    drive_cycle(make_read(1'b1, 5'd9), make_read(1'b0, 5'd7),
                make_write(1'b0, 1'b0, '0, '0));

    repeat (NumRandom) begin
      random_cycle();
    end

    // Last request set still has data in flight
    @(posedge clk_i);
    #1;
    check_outputs();

    $display("Simulation passed");
    $finish;
  end

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    #(TimeoutNs);
    $display("Watchdog: the run did not finish within %0d ns", TimeoutNs);
    $display("Simulation failed");
    $fatal(1, "Run timed out");
  end

endmodule

`default_nettype wire

// File: logic/fp_regfile.sv
/*
  Floating-point register file
  32 writable flop registers, two registered read ports and the write-enable check
*/

`timescale 1ns/1ps
`default_nettype none

module fp_regfile import rf_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  rf_addr_t   rd_addr_a_i,
  input  rf_addr_t   rd_addr_b_i,
  input  rf_wr_req_t wr_req_i,

  output rf_word_t   rdata_a_o,
  output rf_word_t   rdata_b_o,
  output logic       err_o
);

  logic                 wr_en;
  logic [RfNumRegs-1:0] we_dec;
  logic                 we_onehot;
  logic                 err_d, err_q;
  rf_word_t             rf_reg_q [RfNumRegs];
  rf_word_t             rdata_a_q, rdata_b_q;

  //////////////////////////////
  // Write decode
  //////////////////////////////

  assign wr_en = wr_req_i.we & wr_req_i.fp_sel;

  always_comb begin
    we_dec = '0;
    if (wr_en) begin
      we_dec[wr_req_i.addr] = 1'b1;
    end
  end

  assign we_onehot = (we_dec != '0) & ((we_dec & (we_dec - 1'b1)) == '0);
  assign err_d     = wr_en ? ~we_onehot : (we_dec != '0);

  //////////////////////////////
  // Storage
  //////////////////////////////

  // f0 is a normal register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < RfNumRegs; i++) begin
        rf_reg_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < RfNumRegs; i++) begin
        if (we_dec[i]) begin
          rf_reg_q[i] <= wr_req_i.data;
        end
      end
    end
  end

  //////////////////////////////
  // Registered reads
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_a_q <= '0;
      rdata_b_q <= '0;
      err_q     <= 1'b0;
    end else begin
      rdata_a_q <= rf_reg_q[rd_addr_a_i];
      rdata_b_q <= rf_reg_q[rd_addr_b_i];
      err_q     <= err_d;
    end
  end

  assign rdata_a_o = rdata_a_q;
  assign rdata_b_o = rdata_b_q;
  assign err_o     = err_q;

  // At most one register written per edge
  a_we_onehot0: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(we_dec))
    else $error("fp_regfile decoded write enable not one-hot");

endmodule

`default_nettype wire

// File: logic/int_regfile.sv
/*
  Integer register file
  31 flop registers plus hard-wired zero, two registered read ports,
  one write port and a one-hot write-enable glitch check
*/

`timescale 1ns/1ps
`default_nettype none

module int_regfile import rf_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  rf_addr_t   rd_addr_a_i,
  input  rf_addr_t   rd_addr_b_i,
  input  rf_wr_req_t wr_req_i,

  output rf_word_t   rdata_a_o,
  output rf_word_t   rdata_b_o,
  output logic       err_o
);

  logic                 wr_en;
  logic [RfNumRegs-1:0] we_dec;
  logic                 we_onehot;
  logic                 err_d, err_q;
  rf_word_t             rf_reg_q [1:RfNumRegs-1];
  rf_word_t             rf_words [RfNumRegs];
  rf_word_t             rdata_a_q, rdata_b_q;

  //////////////////////////////
  // Write decode
  //////////////////////////////

  // Only integer-file writes count here
  assign wr_en = wr_req_i.we & ~wr_req_i.fp_sel;

  // Bit 0 is decoded for the check but has no storage behind it
  always_comb begin
    we_dec = '0;
    if (wr_en) begin
      we_dec[wr_req_i.addr] = 1'b1;
    end
  end

  assign we_onehot = (we_dec != '0) & ((we_dec & (we_dec - 1'b1)) == '0);

  // Any enable without a write, or a non one-hot enable with one, is a glitch
  assign err_d = wr_en ? ~we_onehot : (we_dec != '0);

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < RfNumRegs; i++) begin
        rf_reg_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < RfNumRegs; i++) begin
        if (we_dec[i]) begin
          rf_reg_q[i] <= wr_req_i.data;
        end
      end
    end
  end

  // x0 reads as zero
  assign rf_words[0] = '0;

  for (genvar g = 1; g < RfNumRegs; g++) begin : gen_words
    assign rf_words[g] = rf_reg_q[g];
  end

  //////////////////////////////
  // Registered reads
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_a_q <= '0;
      rdata_b_q <= '0;
      err_q     <= 1'b0;
    end else begin
      rdata_a_q <= rf_words[rd_addr_a_i];
      rdata_b_q <= rf_words[rd_addr_b_i];
      err_q     <= err_d;
    end
  end

  assign rdata_a_o = rdata_a_q;
  assign rdata_b_o = rdata_b_q;
  assign err_o     = err_q;

  // No glitch alarm in normal operation
  a_no_err: assert property (@(posedge clk_i) disable iff (!rst_ni) !err_o)
    else $error("int_regfile write-enable check fired");

endmodule

`default_nettype wire

// File: logic/rf_pkg.sv
/*
  Register file package
  Sizes and request structs shared by the integer and FP register files
*/

`default_nettype none

package rf_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned RfNumRegs = 32;
  localparam int unsigned RfAddrW   = 5;
  localparam int unsigned RfDataW   = 32;

  typedef logic [RfAddrW-1:0] rf_addr_t;
  typedef logic [RfDataW-1:0] rf_word_t;

  //////////////////////////////
  // Port requests
  //////////////////////////////

  // One read port, fp_sel picks the FP file
  typedef struct packed {
    logic     fp_sel;
    rf_addr_t addr;
  } rf_rd_req_t;

  // Shared write port
  typedef struct packed {
    logic     we;
    logic     fp_sel;
    rf_addr_t addr;
    rf_word_t data;
  } rf_wr_req_t;

endpackage

`default_nettype wire

// File: logic/rf_read_combine.sv
/*
  Read combine stage
  Picks each port's word from the integer or FP file and merges the glitch alarms
*/

`timescale 1ns/1ps
`default_nettype none

module rf_read_combine import rf_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     fp_sel_a_i,
  input  logic     fp_sel_b_i,

  input  rf_word_t int_rdata_a_i,
  input  rf_word_t int_rdata_b_i,
  input  rf_word_t fp_rdata_a_i,
  input  rf_word_t fp_rdata_b_i,

  input  logic     int_err_i,
  input  logic     fp_err_i,

  output rf_word_t rdata_a_o,
  output rf_word_t rdata_b_o,
  output logic     alert_major_o
);

  logic fp_sel_a_q;
  logic fp_sel_b_q;

  //////////////////////////////
  // Select pipeline
  //////////////////////////////

  // Selects follow the addresses into the files' read registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fp_sel_a_q <= 1'b0;
      fp_sel_b_q <= 1'b0;
    end else begin
      fp_sel_a_q <= fp_sel_a_i;
      fp_sel_b_q <= fp_sel_b_i;
    end
  end

  //////////////////////////////
  // Port muxes
  //////////////////////////////

  assign rdata_a_o = fp_sel_a_q ? fp_rdata_a_i : int_rdata_a_i;
  assign rdata_b_o = fp_sel_b_q ? fp_rdata_b_i : int_rdata_b_i;

  // Either file's glitch is a major alert
  assign alert_major_o = int_err_i | fp_err_i;

  a_alert_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !$isunknown(alert_major_o)
  ) else $error("alert_major_o is unknown");

endmodule

`default_nettype wire

// File: logic/rf_subsys_top.sv
/*
  Register file block top
  Integer and FP register files side by side behind one combine stage
*/

`timescale 1ns/1ps
`default_nettype none

module rf_subsys_top import rf_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  rf_rd_req_t rd_req_a_i,
  input  rf_rd_req_t rd_req_b_i,
  input  rf_wr_req_t wr_req_i,

  output rf_word_t   rdata_a_o,
  output rf_word_t   rdata_b_o,
  output logic       alert_major_o
);

  rf_word_t int_rdata_a, int_rdata_b;
  rf_word_t fp_rdata_a, fp_rdata_b;
  logic     int_err, fp_err;

  // Both files see the full write request and pick their own writes
  int_regfile u_int_regfile (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_addr_a_i(rd_req_a_i.addr),
    .rd_addr_b_i(rd_req_b_i.addr),
    .wr_req_i   (wr_req_i),
    .rdata_a_o  (int_rdata_a),
    .rdata_b_o  (int_rdata_b),
    .err_o      (int_err)
  );

  fp_regfile u_fp_regfile (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_addr_a_i(rd_req_a_i.addr),
    .rd_addr_b_i(rd_req_b_i.addr),
    .wr_req_i   (wr_req_i),
    .rdata_a_o  (fp_rdata_a),
    .rdata_b_o  (fp_rdata_b),
    .err_o      (fp_err)
  );

  rf_read_combine u_read_combine (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fp_sel_a_i   (rd_req_a_i.fp_sel),
    .fp_sel_b_i   (rd_req_b_i.fp_sel),
    .int_rdata_a_i(int_rdata_a),
    .int_rdata_b_i(int_rdata_b),
    .fp_rdata_a_i (fp_rdata_a),
    .fp_rdata_b_i (fp_rdata_b),
    .int_err_i    (int_err),
    .fp_err_i     (fp_err),
    .rdata_a_o    (rdata_a_o),
    .rdata_b_o    (rdata_b_o),
    .alert_major_o(alert_major_o)
  );

endmodule

`default_nettype wire

// File: regfile_subsys.f
+incdir+dv
logic/rf_pkg.sv
logic/int_regfile.sv
logic/fp_regfile.sv
logic/rf_read_combine.sv
logic/rf_subsys_top.sv
dv/rf_subsys_tb.sv
